//--- axil_pkg.sv
// ==========================================================
// AXI4-Lite payload types, one packed struct per channel
// valid and ready bits travel beside these as plain ports
// ==========================================================

package axil_pkg;

`include "iob_axil_defs.svh"

   typedef logic [`IOB_AXIL_ADDR_W-1:0]   axil_addr_t;
   typedef logic [`IOB_AXIL_DATA_W-1:0]   axil_data_t;
   typedef logic [`IOB_AXIL_DATA_W/8-1:0] axil_strb_t;
   typedef logic [1:0]                    axil_resp_t;

   // only OKAY is ever returned here
   localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

   // write address channel
   typedef struct packed {
      axil_addr_t addr;
   } axil_aw_t;

   // write data channel
   typedef struct packed {
      axil_data_t data;
      axil_strb_t strb;
   } axil_w_t;

   // write response channel
   typedef struct packed {
      axil_resp_t resp;
   } axil_b_t;

   // read address channel
   typedef struct packed {
      axil_addr_t addr;
   } axil_ar_t;

   // read data channel
   typedef struct packed {
      axil_data_t data;
      axil_resp_t resp;
   } axil_r_t;

endpackage

//--- axil_ram.sv
// ==========================================================
// AXI4-Lite subordinate RAM, one word per beat, byte strobes
// single outstanding read and single outstanding write
// ==========================================================

`timescale 1ns/1ns

`include "iob_axil_defs.svh"

module axil_ram
   import axil_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   // write address
   input  logic     awvalid_i,
   input  axil_aw_t aw_i,
   output logic     awready_o,
   // write data
   input  logic     wvalid_i,
   input  axil_w_t  w_i,
   output logic     wready_o,
   // write response
   output logic     bvalid_o,
   output axil_b_t  b_o,
   input  logic     bready_i,
   // read address
   input  logic     arvalid_i,
   input  axil_ar_t ar_i,
   output logic     arready_o,
   // read data
   output logic     rvalid_o,
   output axil_r_t  r_o,
   input  logic     rready_i
);

   localparam int AW    = `IOB_AXIL_RAM_AW;
   localparam int WORDS = 1 << AW;

   typedef logic [AW-1:0] ram_idx_t;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_WRITE,
      WR_RESP
   } wr_state_t;

   axil_data_t mem [WORDS];

   wr_state_t  wr_state;
   logic       aw_full;
   logic       w_full;
   axil_aw_t   aw_q;
   axil_w_t    w_q;
   logic       aw_hs;
   logic       w_hs;
   ram_idx_t   wr_idx;
   ram_idx_t   rd_idx;
   axil_data_t rd_word;
   logic       ar_hs;
   logic       rvalid_q;
   axil_data_t rdata_q;

   // byte lanes with strobe set take the new data
   function automatic axil_data_t merge_word(input axil_data_t old_w,
                                             input axil_data_t new_w,
                                             input axil_strb_t strb);
      axil_data_t res;
      res = old_w;
      for (int i = 0; i < $bits(axil_strb_t); i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_w[8*i +: 8];
         end
      end
      return res;
   endfunction

   assign awready_o = ~aw_full;
   assign wready_o  = ~w_full;
   assign aw_hs     = awvalid_i & awready_o;
   assign w_hs      = wvalid_i & wready_o;

   // word index, address bits above the RAM wrap
   assign wr_idx = aw_q.addr[AW+1:2];
   assign rd_idx = ar_i.addr[AW+1:2];

   // capture flags stay set until the response is taken,
   // so a new write waits for bready
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_state <= WR_IDLE;
         aw_full  <= 1'b0;
         w_full   <= 1'b0;
      end else begin
         if (aw_hs) begin
            aw_full <= 1'b1;
         end
         if (w_hs) begin
            w_full <= 1'b1;
         end
         case (wr_state)
            WR_IDLE: begin
               if ((aw_full | aw_hs) & (w_full | w_hs)) begin
                  wr_state <= WR_WRITE;
               end
            end
            WR_WRITE: begin
               wr_state <= WR_RESP;
            end
            WR_RESP: begin
               if (bready_i) begin
                  aw_full  <= 1'b0;
                  w_full   <= 1'b0;
                  wr_state <= WR_IDLE;
               end
            end
            default: wr_state <= WR_IDLE;
         endcase
      end
   end

   // capture registers
   always_ff @(posedge clk_i) begin
      if (aw_hs) begin
         aw_q <= aw_i;
      end
      if (w_hs) begin
         w_q <= w_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_state == WR_WRITE) begin
         mem[wr_idx] <= merge_word(mem[wr_idx], w_q.data, w_q.strb);
      end
   end

   assign bvalid_o = (wr_state == WR_RESP);
   assign b_o      = '{resp: AXIL_RESP_OKAY};

   // a read landing on the word being written sees the new bytes
   assign rd_word = ((wr_state == WR_WRITE) && (rd_idx == wr_idx)) ?
                    merge_word(mem[rd_idx], w_q.data, w_q.strb) : mem[rd_idx];

   assign arready_o = ~rvalid_q;
   assign ar_hs     = arvalid_i & arready_o;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_q <= 1'b0;
      end else if (ar_hs) begin
         rvalid_q <= 1'b1;
      end else if (rready_i) begin
         rvalid_q <= 1'b0;
      end
   end

   // read data holding register
   always_ff @(posedge clk_i) begin
      if (ar_hs) begin
         rdata_q <= rd_word;
      end
   end

   assign rvalid_o = rvalid_q;
   assign r_o      = '{data: rdata_q, resp: AXIL_RESP_OKAY};

endmodule

//--- iob_axil_defs.svh
// ==========================================================
// widths and depths shared by the IOb to AXI-Lite subsystem
// include wherever a width or depth macro is needed
// ==========================================================

`ifndef IOB_AXIL_DEFS_SVH
`define IOB_AXIL_DEFS_SVH

// byte address width on both buses
`define IOB_AXIL_ADDR_W 12

// data width on both buses
`define IOB_AXIL_DATA_W 32

// word index bits of the RAM, 256 words
// upper address bits are dropped so addresses wrap
`define IOB_AXIL_RAM_AW 8

// entries in the IOb request buffer
`define IOB_AXIL_BUF_DEPTH 2

`endif

//--- iob_axil_sys.sv
// ==========================================================
// top level: IOb subordinate port into buffer, bridge, RAM
// ==========================================================

`timescale 1ns/1ns

module iob_axil_sys
   import iob_pkg::*;
   import axil_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      iob_valid_i,
   input  iob_req_t  iob_req_i,
   output logic      iob_ready_o,
   input  logic      iob_rready_i,
   output logic      iob_rvalid_o,
   output iob_data_t iob_rdata_o
);

   // buffer to bridge
   logic     buf_valid;
   iob_req_t buf_req;
   logic     bridge_ready;

   // bridge to RAM
   logic     awvalid;
   axil_aw_t aw;
   logic     awready;
   logic     wvalid;
   axil_w_t  w;
   logic     wready;
   logic     bvalid;
   axil_b_t  b;
   logic     bready;
   logic     arvalid;
   axil_ar_t ar;
   logic     arready;
   logic     rvalid;
   axil_r_t  r;
   logic     rready;

   iob_req_buffer u_buf (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .in_valid_i (iob_valid_i),
      .in_req_i   (iob_req_i),
      .in_ready_o (iob_ready_o),
      .out_valid_o(buf_valid),
      .out_req_o  (buf_req),
      .out_ready_i(bridge_ready)
   );

   iob_iob2axil u_bridge (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .iob_valid_i (buf_valid),
      .iob_req_i   (buf_req),
      .iob_ready_o (bridge_ready),
      .iob_rready_i(iob_rready_i),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o),
      .awvalid_o   (awvalid),
      .aw_o        (aw),
      .awready_i   (awready),
      .wvalid_o    (wvalid),
      .w_o         (w),
      .wready_i    (wready),
      .bvalid_i    (bvalid),
      .b_i         (b),
      .bready_o    (bready),
      .arvalid_o   (arvalid),
      .ar_o        (ar),
      .arready_i   (arready),
      .rvalid_i    (rvalid),
      .r_i         (r),
      .rready_o    (rready)
   );

   axil_ram u_ram (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .awvalid_i(awvalid),
      .aw_i     (aw),
      .awready_o(awready),
      .wvalid_i (wvalid),
      .w_i      (w),
      .wready_o (wready),
      .bvalid_o (bvalid),
      .b_o      (b),
      .bready_i (bready),
      .arvalid_i(arvalid),
      .ar_i     (ar),
      .arready_o(arready),
      .rvalid_o (rvalid),
      .r_o      (r),
      .rready_i (rready)
   );

endmodule

//--- iob_iob2axil.sv
// ==========================================================
// IOb subordinate to AXI4-Lite manager bridge
// strobes pick read or write, read data passes straight back
// ==========================================================

`timescale 1ns/1ns

module iob_iob2axil
   import iob_pkg::*;
   import axil_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   // IOb request side
   input  logic      iob_valid_i,
   input  iob_req_t  iob_req_i,
   output logic      iob_ready_o,
   // IOb read data side
   input  logic      iob_rready_i,
   output logic      iob_rvalid_o,
   output iob_data_t iob_rdata_o,
   // write address
   output logic      awvalid_o,
   output axil_aw_t  aw_o,
   input  logic      awready_i,
   // write data
   output logic      wvalid_o,
   output axil_w_t   w_o,
   input  logic      wready_i,
   // write response
   input  logic      bvalid_i,
   input  axil_b_t   b_i,
   output logic      bready_o,
   // read address
   output logic      arvalid_o,
   output axil_ar_t  ar_o,
   input  logic      arready_i,
   // read data
   input  logic      rvalid_i,
   input  axil_r_t   r_i,
   output logic      rready_o
);

   logic is_write;
   logic aw_hs;
   logic wvalid_q;

   assign is_write = |iob_req_i.wstrb;

   // write address goes first, data only once the address is taken
   assign awvalid_o = iob_valid_i & is_write & ~wvalid_q;
   assign aw_hs     = awvalid_o & awready_i;
   assign aw_o      = '{addr: iob_req_i.addr};

   // wvalid flag
   // wready is often high while idle, so only a taken beat clears it
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wvalid_q <= 1'b0;
      end else if (wvalid_q & wready_i) begin
         wvalid_q <= 1'b0;
      end else if (aw_hs) begin
         wvalid_q <= 1'b1;
      end
   end

   assign wvalid_o = wvalid_q;
   assign w_o      = '{data: iob_req_i.wdata, strb: iob_req_i.wstrb};

   // reads need a single address beat
   assign arvalid_o = iob_valid_i & ~is_write;
   assign ar_o      = '{addr: iob_req_i.addr};

   // request done on the data beat for writes, the address beat for reads
   assign iob_ready_o = is_write ? (wvalid_q & wready_i) : arready_i;

   // responses share the outside read-ready
   // b is drained but not reported, the RAM only answers OKAY
   assign bready_o = iob_rready_i;
   assign rready_o = iob_rready_i;

   assign iob_rvalid_o = rvalid_i;
   assign iob_rdata_o  = r_i.data;

endmodule

//--- iob_pkg.sv
// ==========================================================
// IOb native bus types: address, data, strobes and the
// request bundle that travels through the request buffer
// ==========================================================

package iob_pkg;

`include "iob_axil_defs.svh"

   // byte address
   typedef logic [`IOB_AXIL_ADDR_W-1:0] iob_addr_t;

   // read and write data
   typedef logic [`IOB_AXIL_DATA_W-1:0] iob_data_t;

   // byte strobes, zero means read
   typedef logic [`IOB_AXIL_DATA_W/8-1:0] iob_strb_t;

   // one IOb request as held in the buffer
   typedef struct packed {
      iob_addr_t addr;
      iob_data_t wdata;
      iob_strb_t wstrb;
   } iob_req_t;

endpackage

//--- iob_req_buffer.sv
// ==========================================================
// small circular FIFO of IOb requests, valid/ready each side
// sits between the external port and the AXI-Lite bridge
// ==========================================================

`timescale 1ns/1ns

`include "iob_axil_defs.svh"

module iob_req_buffer
   import iob_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   // upstream side
   input  logic     in_valid_i,
   input  iob_req_t in_req_i,
   output logic     in_ready_o,
   // downstream side
   output logic     out_valid_o,
   output iob_req_t out_req_o,
   input  logic     out_ready_i
);

   localparam int DEPTH = `IOB_AXIL_BUF_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] cnt_t;

   iob_req_t entries [DEPTH];
   ptr_t     wr_ptr;
   ptr_t     rd_ptr;
   cnt_t     count;
   logic     push;
   logic     pop;

   // wrap at DEPTH, which need not be a power of two
   function automatic ptr_t next_ptr(input ptr_t p);
      return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready_o  = (count != cnt_t'(DEPTH));
   assign out_valid_o = (count != '0);
   assign out_req_o   = entries[rd_ptr];

   assign push = in_valid_i & in_ready_o;
   assign pop  = out_valid_o & out_ready_i;

   // pointers and occupancy
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // storage, payload only
   always_ff @(posedge clk_i) begin
      if (push) begin
         entries[wr_ptr] <= in_req_i;
      end
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, judge the result from the log
set -e

cd "$(dirname "$0")"

TOP=tb_iob_axil_sys
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
   --top-module "$TOP" -f sources.f -o "$TOP"

# a failing run stops with a nonzero status, the log decides the result
./obj_dir/"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   echo "result: FAIL"
   exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
   echo "result: FAIL, no pass line in $LOG"
   exit 1
fi
echo "result: PASS"

//--- sources.f
+incdir+.
iob_pkg.sv
axil_pkg.sv
iob_req_buffer.sv
iob_iob2axil.sv
axil_ram.sv
iob_axil_sys.sv
tb_iob_axil_sys.sv

//--- tb_iob_axil_sys.sv
// ==========================================================
// testbench for the IOb to AXI-Lite memory subsystem
// random IOb traffic checked against a reference memory model
// ==========================================================

`timescale 1ns/1ns

`include "iob_axil_defs.svh"

module tb_iob_axil_sys
   import iob_pkg::*;
();

   localparam int RESET_CYCLES  = 8;
   localparam int RAM_WORDS     = 1 << `IOB_AXIL_RAM_AW;
   localparam int DIRECTED_REQS = 11;
   localparam int RANDOM_REQS   = 400;
   localparam int NUM_REQS      = RAM_WORDS + DIRECTED_REQS + 2 * RANDOM_REQS;
   // 20 cycles per request, plus reset and drain margin
   localparam int TIMEOUT_CYCLES = 20 * NUM_REQS + RESET_CYCLES + 200;
   // longest wait for the last reads to come back
   localparam int DRAIN_CYCLES   = 100;

   typedef logic [`IOB_AXIL_RAM_AW-1:0] model_idx_t;

   logic      clk_i;
   logic      reset_i;
   logic      iob_valid_i;
   iob_req_t  iob_req_i;
   logic      iob_ready_o;
   logic      iob_rready_i;
   logic      iob_rvalid_o;
   iob_data_t iob_rdata_o;

   integer    seed = 32'h32bd;
   logic      rready_random = 1'b0;

   // reference memory and expected read stream
   iob_data_t model_mem [RAM_WORDS];
   iob_data_t exp_q [$];
   iob_addr_t addr_q [$];

   iob_axil_sys uut (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .iob_valid_i (iob_valid_i),
      .iob_req_i   (iob_req_i),
      .iob_ready_o (iob_ready_o),
      .iob_rready_i(iob_rready_i),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // applies a request to the model, returns the word as it then reads
   function automatic iob_data_t model_access(input iob_req_t req);
      model_idx_t idx;
      iob_data_t  word;
      idx  = req.addr[`IOB_AXIL_RAM_AW+1:2];
      word = model_mem[idx];
      for (int b = 0; b < $bits(iob_strb_t); b++) begin
         if (req.wstrb[b]) begin
            word[8*b +: 8] = req.wdata[8*b +: 8];
         end
      end
      model_mem[idx] = word;
      return word;
   endfunction

   function automatic iob_req_t make_req(input iob_addr_t addr, input iob_data_t data,
                                         input iob_strb_t strb);
      iob_req_t req;
      req.addr  = addr;
      req.wdata = data;
      req.wstrb = strb;
      return req;
   endfunction

   // initial contents built from the full byte address
   function automatic iob_data_t fill_word(input iob_addr_t addr);
      return {4'ha, addr, 4'h5, ~addr};
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      if (actual !== expected) begin
         $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual,
                  expected);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   // called 1 ns after a rising edge, returns 1 ns after the transfer edge
   task automatic send_req(input iob_req_t req);
      iob_valid_i = 1'b1;
      iob_req_i   = req;
      @(negedge clk_i);
      while (!iob_ready_o) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      iob_valid_i = 1'b0;
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic run_random(input int count);
      iob_req_t req;
      int       r;
      int       gap;
      for (int n = 0; n < count; n++) begin
         r         = $random(seed);
         req.addr  = iob_addr_t'($random(seed));
         req.wdata = $random(seed);
         // half the traffic lands on a few words for more read after write hits
         if (r[0]) begin
            req.addr[`IOB_AXIL_RAM_AW+1:4] = '0;
         end
         if (r[1]) begin
            req.wstrb = iob_strb_t'($random(seed));
            if (req.wstrb == '0) begin
               req.wstrb = '1;
            end
         end else begin
            req.wstrb = '0;
         end
         send_req(req);
         gap = r[4] ? int'(r[3:2]) : 0;
         idle_cycles(gap);
      end
   endtask

   // record each accepted request, reads queue their expected word
   always @(negedge clk_i) begin : track_requests
      iob_data_t word;
      if (!reset_i && iob_valid_i && iob_ready_o) begin
         word = model_access(iob_req_i);
         if (iob_req_i.wstrb == '0) begin
            exp_q.push_back(word);
            addr_q.push_back(iob_req_i.addr);
         end
      end
   end

   always @(negedge clk_i) begin : compare_reads
      iob_data_t expected;
      iob_addr_t addr;
      if (!reset_i && iob_rvalid_o && iob_rready_i) begin
         if (exp_q.size() == 0) begin
            $display("Error at %0t ns: read data returned with no read outstanding",
                     $time);
            $display("Simulation failed");
            $fatal(1);
         end else begin
            expected = exp_q.pop_front();
            addr     = addr_q.pop_front();
            check_value(iob_rdata_o, expected, $sformatf("read of address %h", addr));
         end
      end
   end

   // read-ready goes random only in the back-pressure phase
   initial begin : drive_rready
      int r;
      iob_rready_i = 1'b1;
      forever begin
         @(posedge clk_i);
         r = $random(seed);
         #1;
         iob_rready_i = rready_random ? r[0] : 1'b1;
      end
   end

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge clk_i);
      $display("Error at %0t ns: timeout, the DUT stopped answering requests", $time);
      $display("Simulation failed");
      $fatal(1);
   end

   initial begin : main_sequence
      int drain_cycles;
      reset_i     = 1'b1;
      iob_valid_i = 1'b0;
      iob_req_i   = '0;

      // no read data while in reset
      repeat (RESET_CYCLES - 1) begin
         @(negedge clk_i);
         check_value({31'b0, iob_rvalid_o}, 32'd0, "rvalid during reset");
      end
      @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      repeat (3) begin
         @(negedge clk_i);
         check_value({31'b0, iob_rvalid_o}, 32'd0, "rvalid after reset");
      end
      @(posedge clk_i);
      #1;

      // known contents everywhere before any read
      for (int i = 0; i < RAM_WORDS; i++) begin
         send_req(make_req(iob_addr_t'(i * 4), fill_word(iob_addr_t'(i * 4)), '1));
      end
      idle_cycles(2);

      // full word write, read back
      send_req(make_req(12'h010, 32'hcafe_f00d, 4'hf));
      send_req(make_req(12'h010, '0, '0));
      idle_cycles(1);

      // partial strobes
      send_req(make_req(12'h020, 32'h1122_3344, 4'b0101));
      send_req(make_req(12'h020, '0, '0));
      send_req(make_req(12'h020, 32'haabb_ccdd, 4'b1000));
      send_req(make_req(12'h020, '0, '0));
      idle_cycles(1);

      // addresses past the RAM wrap onto low words
      send_req(make_req(12'h434, 32'h0bad_c0de, 4'hf));
      send_req(make_req(12'h034, '0, '0));
      send_req(make_req(12'hc34, '0, '0));
      send_req(make_req(12'hffc, 32'h1234_5678, 4'b0011));
      send_req(make_req(12'h3fc, '0, '0));
      idle_cycles(2);

      run_random(RANDOM_REQS);
      idle_cycles(2);

      // same traffic under read back-pressure
      rready_random = 1'b1;
      run_random(RANDOM_REQS);
      idle_cycles(2);
      rready_random = 1'b0;

      // outstanding reads drain within a bounded time
      drain_cycles = 0;
      while (exp_q.size() != 0 && drain_cycles < DRAIN_CYCLES) begin
         @(negedge clk_i);
         drain_cycles++;
      end
      // a few more cycles so a stray extra read shows up
      repeat (10) @(negedge clk_i);
      check_value(exp_q.size(), 32'd0, "reads left outstanding");

      $display("Simulation passed");
      $finish;
   end

endmodule
